// ==== asteroids_pkg.sv ====
/*
  asteroids wrapper shared definitions
  bridge address map, setting and key field layout,
  arcade button vector and video pixel types
*/

package asteroids_pkg;

  //////////////////////////////////////////////////////////////////////
  // bridge bus
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  // settings register map
  localparam bridge_addr_t ADDR_LANGUAGE   = 32'h8000_0000;
  localparam bridge_addr_t ADDR_SHIP_COUNT = 32'h9000_0000;
  localparam bridge_addr_t ADDR_TEST_MODE  = 32'h1000_0000;

  // width of one game setting field
  localparam int SETTING_W = 2;
  typedef logic [SETTING_W-1:0] setting_t;

  //////////////////////////////////////////////////////////////////////
  // controllers
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] key_word_t;

  // bit positions inside a controller key word
  localparam int KEY_LEFT  = 2;
  localparam int KEY_RIGHT = 3;
  localparam int KEY_A     = 4;
  localparam int KEY_B     = 5;
  localparam int KEY_X     = 6;
  localparam int KEY_Y     = 7;
  localparam int KEY_START = 15;

  // arcade buttons, active low
  typedef logic [7:0] button_vec_t;

  //////////////////////////////////////////////////////////////////////
  // video
  //////////////////////////////////////////////////////////////////////

  typedef logic [3:0] rgb4_t;

  // one game pixel with its timing flags, 16 bits
  typedef struct packed {
    rgb4_t red;
    rgb4_t green;
    rgb4_t blue;
    logic  hsync;
    logic  vsync;
    logic  hblank;
    logic  vblank;
  } game_pixel_t;

  typedef logic [23:0] rgb24_t;

endpackage

// ==== bridge_if.sv ====
/*
  bridge register bus
  single-cycle writes, combinational read data
*/

interface bridge_if import asteroids_pkg::*; ();

  // address and write strobe, no handshake
  bridge_addr_t addr;
  logic         wr;

  // write data broadcast to every register
  bridge_data_t wr_data;

  // read data follows addr in the same cycle
  bridge_data_t rd_data;

  // bus side, drives the request
  modport master (
    output addr,
    output wr,
    output wr_data,
    input  rd_data
  );

  // register block side, answers with read data
  modport regs (
    input  addr,
    input  wr,
    input  wr_data,
    output rd_data
  );

endinterface

// ==== core_settings_regs.sv ====
/*
  game settings registers
  language, ship count and self-test mode written over the bridge,
  with readback decode of the same three addresses
*/

module core_settings_regs import asteroids_pkg::*; (
  input  logic      clk_25_175,
  input  logic      reset,
  bridge_if.regs    bus,
  output setting_t  language,
  output setting_t  ship_count,
  output logic      self_test_switch_l
);

  //////////////////////////////////////////////////////////////////////
  // register storage
  //////////////////////////////////////////////////////////////////////

  setting_t language_q;
  setting_t ship_count_q;
  logic     test_mode_q;

  // address decode
  logic hit_language;
  logic hit_ship_count;
  logic hit_test_mode;

  assign hit_language   = (bus.addr == ADDR_LANGUAGE);
  assign hit_ship_count = (bus.addr == ADDR_SHIP_COUNT);
  assign hit_test_mode  = (bus.addr == ADDR_TEST_MODE);

  // one write per edge with wr high
  always_ff @(posedge clk_25_175) begin
    if (reset) begin
      language_q   <= '0;
      ship_count_q <= '0;
      test_mode_q  <= 1'b0;
    end else if (bus.wr) begin
      if (hit_language) begin
        language_q <= bus.wr_data[SETTING_W-1:0];
      end
      if (hit_ship_count) begin
        ship_count_q <= bus.wr_data[SETTING_W-1:0];
      end
      // test mode keeps only bit 0
      if (hit_test_mode) begin
        test_mode_q <= bus.wr_data[0];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////////////////////////

  // zero-extended fields and zero for unmapped addresses
  always_comb begin
    bus.rd_data = '0;
    if (hit_language) begin
      bus.rd_data = bridge_data_t'(language_q);
    end else if (hit_ship_count) begin
      bus.rd_data = bridge_data_t'(ship_count_q);
    end else if (hit_test_mode) begin
      bus.rd_data = bridge_data_t'(test_mode_q);
    end
  end

  // settings out to the game core
  assign language           = language_q;
  assign ship_count         = ship_count_q;
  // switch input of the game is active low
  assign self_test_switch_l = ~test_mode_q;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // unmapped reads never leak register contents
  assert property (@(posedge clk_25_175) disable iff (reset)
    !(hit_language || hit_ship_count || hit_test_mode) |-> (bus.rd_data == '0));

endmodule

// ==== input_sync.sv ====
/*
  two-stage synchronizer
  brings a word of any packed payload type into clk_25_175
*/

module input_sync #(
  // key words and game pixels share this block
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk_25_175,
  input  logic     reset,
  input  payload_t d,
  output payload_t q
);

  // first stage may go metastable
  payload_t stage1;
  // second stage is safe to use
  payload_t stage2;

  always_ff @(posedge clk_25_175) begin
    if (reset) begin
      stage1 <= '0;
      stage2 <= '0;
    end else begin
      stage1 <= d;
      stage2 <= stage1;
    end
  end

  // output is the settled stage, two edges after d
  assign q = stage2;

endmodule

// ==== arcade_button_map.sv ====
/*
  arcade button mapping
  folds two synchronized controllers into the eight active-low
  cabinet buttons, start buttons kept per player
*/

module arcade_button_map import asteroids_pkg::*; (
  input  key_word_t   p1_keys,
  input  key_word_t   p2_keys,
  output button_vec_t button_vec
);

  //////////////////////////////////////////////////////////////////////
  // shared controls
  //////////////////////////////////////////////////////////////////////

  // either player may steer or fire
  logic right_any;
  logic left_any;
  logic fire_any;
  logic face_y_any;
  logic thrust_any;
  logic hyper_any;

  assign right_any  = p1_keys[KEY_RIGHT] | p2_keys[KEY_RIGHT];
  assign left_any   = p1_keys[KEY_LEFT]  | p2_keys[KEY_LEFT];
  // fire on face a
  assign fire_any   = p1_keys[KEY_A]     | p2_keys[KEY_A];
  assign face_y_any = p1_keys[KEY_Y]     | p2_keys[KEY_Y];
  // thrust on face x
  assign thrust_any = p1_keys[KEY_X]     | p2_keys[KEY_X];
  // hyperspace on face b
  assign hyper_any  = p1_keys[KEY_B]     | p2_keys[KEY_B];

  //////////////////////////////////////////////////////////////////////
  // cabinet vector
  //////////////////////////////////////////////////////////////////////

  // bit 7 down to bit 0, all inverted for the game
  assign button_vec = ~{
    right_any,
    left_any,
    // starts stay with their own player
    p1_keys[KEY_START],
    p2_keys[KEY_START],
    fire_any,
    face_y_any,
    thrust_any,
    hyper_any
  };

endmodule

// ==== video_scan_out.sv ====
/*
  video scan out
  expands 4-bit game colour to 24-bit rgb with data enable,
  and turns hsync and vsync rising edges into one-cycle pulses
*/

module video_scan_out import asteroids_pkg::*; (
  input  logic        clk_25_175,
  input  logic        reset,
  input  game_pixel_t pixel,
  output rgb24_t      video_rgb,
  output logic        video_de,
  output logic        video_hs,
  output logic        video_vs
);

  //////////////////////////////////////////////////////////////////////
  // pixel expansion
  //////////////////////////////////////////////////////////////////////

  // visible area only outside both blanks
  logic   active;
  rgb24_t rgb_expanded;

  assign active = ~(pixel.hblank | pixel.vblank);

  // nibble repeated so full scale maps to 8'hff
  assign rgb_expanded = {
    {2{pixel.red}},
    {2{pixel.green}},
    {2{pixel.blue}}
  };

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  // previous sync levels for edge detect
  logic hs_prev;
  logic vs_prev;

  always_ff @(posedge clk_25_175) begin
    if (reset) begin
      video_rgb <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
    end else begin
      // black during blanking
      video_rgb <= active ? rgb_expanded : '0;
      video_de  <= active;
      // pulse on the low to high step only
      video_hs  <= pixel.hsync & ~hs_prev;
      video_vs  <= pixel.vsync & ~vs_prev;
      hs_prev   <= pixel.hsync;
      vs_prev   <= pixel.vsync;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  // a held sync level gives a single pulse
  assert property (@(posedge clk_25_175) disable iff (reset)
    video_hs |=> !video_hs);

  assert property (@(posedge clk_25_175) disable iff (reset)
    video_vs |=> !video_vs);

endmodule

// ==== asteroids_core_wrap.sv ====
/*
  asteroids core wrapper
  bridge settings registers, controller mapping and video scan out
  around an external game core, all on clk_25_175
*/

module asteroids_core_wrap import asteroids_pkg::*; (
  input  logic         clk_25_175,
  input  logic         reset,
  // bridge register bus
  input  bridge_addr_t bridge_addr,
  input  logic         bridge_wr,
  input  bridge_data_t bridge_wr_data,
  output bridge_data_t bridge_rd_data,
  // controllers
  input  key_word_t    cont1_key,
  input  key_word_t    cont2_key,
  // game core video
  input  rgb4_t        game_r,
  input  rgb4_t        game_g,
  input  rgb4_t        game_b,
  input  logic         game_hs,
  input  logic         game_vs,
  input  logic         game_hblank,
  input  logic         game_vblank,
  // to the game core
  output setting_t     language,
  output setting_t     ship_count,
  output logic         self_test_switch_l,
  output button_vec_t  button_vec,
  // to the scaler
  output rgb24_t       video_rgb,
  output logic         video_de,
  output logic         video_hs,
  output logic         video_vs
);

  //////////////////////////////////////////////////////////////////////
  // settings
  //////////////////////////////////////////////////////////////////////

  // master side of the bus driven from the plain ports
  bridge_if bus ();

  assign bus.addr       = bridge_addr;
  assign bus.wr         = bridge_wr;
  assign bus.wr_data    = bridge_wr_data;
  assign bridge_rd_data = bus.rd_data;

  core_settings_regs u_settings (
    .clk_25_175         (clk_25_175),
    .reset              (reset),
    .bus                (bus.regs),
    .language           (language),
    .ship_count         (ship_count),
    .self_test_switch_l (self_test_switch_l)
  );

  //////////////////////////////////////////////////////////////////////
  // controllers
  //////////////////////////////////////////////////////////////////////

  key_word_t cont1_key_s;
  key_word_t cont2_key_s;

  input_sync #(.payload_t(key_word_t)) u_cont1_sync (
    .clk_25_175 (clk_25_175),
    .reset      (reset),
    .d          (cont1_key),
    .q          (cont1_key_s)
  );

  input_sync #(.payload_t(key_word_t)) u_cont2_sync (
    .clk_25_175 (clk_25_175),
    .reset      (reset),
    .d          (cont2_key),
    .q          (cont2_key_s)
  );

  // combinational after the synchronizers
  arcade_button_map u_button_map (
    .p1_keys    (cont1_key_s),
    .p2_keys    (cont2_key_s),
    .button_vec (button_vec)
  );

  //////////////////////////////////////////////////////////////////////
  // video
  //////////////////////////////////////////////////////////////////////

  game_pixel_t game_pixel;
  game_pixel_t game_pixel_s;

  // bundle the game outputs into one word
  assign game_pixel = '{
    red:    game_r,
    green:  game_g,
    blue:   game_b,
    hsync:  game_hs,
    vsync:  game_vs,
    hblank: game_hblank,
    vblank: game_vblank
  };

  input_sync #(.payload_t(game_pixel_t)) u_pixel_sync (
    .clk_25_175 (clk_25_175),
    .reset      (reset),
    .d          (game_pixel),
    .q          (game_pixel_s)
  );

  video_scan_out u_scan_out (
    .clk_25_175 (clk_25_175),
    .reset      (reset),
    .pixel      (game_pixel_s),
    .video_rgb  (video_rgb),
    .video_de   (video_de),
    .video_hs   (video_hs),
    .video_vs   (video_vs)
  );

endmodule

// ==== tb_asteroids_core_wrap.sv ====
/*
  directed testbench for the asteroids core wrapper
  settings bus, button mapping, pixel expansion and sync pulses
*/

module tb_asteroids_core_wrap import asteroids_pkg::*; ();

  // test lengths in clock cycles
  localparam int NUM_KEY_VECS    = 24;
  localparam int NUM_PIXELS      = 24;
  localparam int SYNC_HOLD       = 8;
  localparam int RESET_CYCLES    = 3;
  localparam int SETTINGS_CYCLES = 14;
  localparam int BUTTON_CYCLES   = (NUM_KEY_VECS + 1) * 2;
  localparam int PIXEL_CYCLES    = NUM_PIXELS * 3;
  localparam int SYNC_CYCLES     = 2 * (SYNC_HOLD + 6);
  localparam int TIMEOUT_CYCLES  =
    2 * (RESET_CYCLES + SETTINGS_CYCLES + BUTTON_CYCLES + PIXEL_CYCLES + SYNC_CYCLES);

  logic         clk_25_175;
  logic         reset;
  bridge_addr_t bridge_addr;
  logic         bridge_wr;
  bridge_data_t bridge_wr_data;
  bridge_data_t bridge_rd_data;
  key_word_t    cont1_key;
  key_word_t    cont2_key;
  rgb4_t        game_r;
  rgb4_t        game_g;
  rgb4_t        game_b;
  logic         game_hs;
  logic         game_vs;
  logic         game_hblank;
  logic         game_vblank;
  setting_t     language;
  setting_t     ship_count;
  logic         self_test_switch_l;
  button_vec_t  button_vec;
  rgb24_t       video_rgb;
  logic         video_de;
  logic         video_hs;
  logic         video_vs;

  integer seed;
  int     error_count;
  int     check_count;
  int     cycle_count;

  asteroids_core_wrap UUT (
    .clk_25_175         (clk_25_175),
    .reset              (reset),
    .bridge_addr        (bridge_addr),
    .bridge_wr          (bridge_wr),
    .bridge_wr_data     (bridge_wr_data),
    .bridge_rd_data     (bridge_rd_data),
    .cont1_key          (cont1_key),
    .cont2_key          (cont2_key),
    .game_r             (game_r),
    .game_g             (game_g),
    .game_b             (game_b),
    .game_hs            (game_hs),
    .game_vs            (game_vs),
    .game_hblank        (game_hblank),
    .game_vblank        (game_vblank),
    .language           (language),
    .ship_count         (ship_count),
    .self_test_switch_l (self_test_switch_l),
    .button_vec         (button_vec),
    .video_rgb          (video_rgb),
    .video_de           (video_de),
    .video_hs           (video_hs),
    .video_vs           (video_vs)
  );

  // 100 unit period
  always #50 clk_25_175 = ~clk_25_175;

  // run limit
  always @(posedge clk_25_175) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_setting(input setting_t got, input setting_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input bridge_data_t got, input bridge_data_t exp,
                            input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_buttons(input button_vec_t got, input button_vec_t exp,
                               input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_rgb(input rgb24_t got, input rgb24_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus and stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // every helper starts and ends on a falling edge
  task automatic bridge_write(input bridge_addr_t addr, input bridge_data_t data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(negedge clk_25_175);
    bridge_wr      = 1'b0;
  endtask

  task automatic bridge_read_check(input bridge_addr_t addr, input bridge_data_t exp,
                                   input string what);
    bridge_addr = addr;
    @(negedge clk_25_175);
    check_data(bridge_rd_data, exp, what);
  endtask

  // reference mapping from bit 7 down to 0
  function automatic button_vec_t expected_buttons(input key_word_t p1, input key_word_t p2);
    button_vec_t pressed;
    pressed[7] = p1[KEY_RIGHT] | p2[KEY_RIGHT];
    pressed[6] = p1[KEY_LEFT] | p2[KEY_LEFT];
    pressed[5] = p1[KEY_START];
    pressed[4] = p2[KEY_START];
    // fire, face y, thrust, hyperspace
    pressed[3] = p1[KEY_A] | p2[KEY_A];
    pressed[2] = p1[KEY_Y] | p2[KEY_Y];
    pressed[1] = p1[KEY_X] | p2[KEY_X];
    pressed[0] = p1[KEY_B] | p2[KEY_B];
    return ~pressed;
  endfunction

  task automatic keys_check(input key_word_t p1, input key_word_t p2);
    cont1_key = p1;
    cont2_key = p2;
    // two synchronizer edges
    repeat (2) @(negedge clk_25_175);
    check_buttons(button_vec, expected_buttons(p1, p2), "button_vec");
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  // no edge since the release, so every register still shows its reset value
  task automatic test_reset_state();
    check_setting(language, '0, "language after reset");
    check_setting(ship_count, '0, "ship_count after reset");
    check_bit(self_test_switch_l, 1'b1, "self_test_switch_l after reset");
    check_buttons(button_vec, 8'hff, "button_vec after reset");
    check_bit(video_de, 1'b0, "video_de after reset");
    check_bit(video_hs, 1'b0, "video_hs after reset");
    check_bit(video_vs, 1'b0, "video_vs after reset");
    check_rgb(video_rgb, '0, "video_rgb after reset");
  endtask

  task automatic test_settings();
    // upper data bits set so only the low field may stick
    bridge_write(ADDR_LANGUAGE, 32'habcd_0126);
    check_setting(language, 2'b10, "language write");
    bridge_write(ADDR_SHIP_COUNT, 32'h5a5a_a5a7);
    check_setting(ship_count, 2'b11, "ship_count write");
    check_setting(language, 2'b10, "language kept");
    bridge_write(ADDR_TEST_MODE, 32'h0000_0003);
    check_bit(self_test_switch_l, 1'b0, "self_test_switch_l on");
    // zero-extended readback
    bridge_read_check(ADDR_LANGUAGE, 32'h2, "language readback");
    bridge_read_check(ADDR_SHIP_COUNT, 32'h3, "ship_count readback");
    bridge_read_check(ADDR_TEST_MODE, 32'h1, "test mode readback");
    bridge_read_check(32'h8000_0004, 32'h0, "unmapped readback");
    // switch back off
    bridge_write(ADDR_TEST_MODE, 32'hffff_fffe);
    check_bit(self_test_switch_l, 1'b1, "self_test_switch_l off");
    bridge_read_check(ADDR_TEST_MODE, 32'h0, "test mode readback off");
    bridge_addr = '0;
  endtask

  task automatic test_buttons();
    key_word_t p1;
    key_word_t p2;
    // only player 2 start
    keys_check('0, key_word_t'(1) << KEY_START);
    for (int i = 0; i < NUM_KEY_VECS; i++) begin
      p1 = $random(seed);
      p2 = $random(seed);
      keys_check(p1, p2);
    end
    cont1_key = '0;
    cont2_key = '0;
  endtask

  task automatic test_pixels();
    rgb24_t exp_rgb;
    logic   exp_de;
    for (int i = 0; i < NUM_PIXELS; i++) begin
      game_r      = $random(seed);
      game_g      = $random(seed);
      game_b      = $random(seed);
      // cycle through active, hblank, vblank, active
      game_hblank = (i % 4 == 1);
      game_vblank = (i % 4 == 2);
      exp_de      = !(game_hblank || game_vblank);
      exp_rgb     = exp_de ? {8'(game_r) * 8'h11, 8'(game_g) * 8'h11, 8'(game_b) * 8'h11}
                           : 24'h0;
      // sync plus output register
      repeat (3) @(negedge clk_25_175);
      check_bit(video_de, exp_de, "video_de");
      check_rgb(video_rgb, exp_rgb, "video_rgb");
    end
    game_hblank = 1'b0;
    game_vblank = 1'b0;
  endtask

  // sync held high for several cycles gives one pulse on the third edge
  task automatic sync_pulse_check(input logic vertical);
    logic got;
    repeat (3) @(negedge clk_25_175);
    if (vertical) game_vs = 1'b1;
    else game_hs = 1'b1;
    for (int k = 1; k <= SYNC_HOLD; k++) begin
      @(negedge clk_25_175);
      got = vertical ? video_vs : video_hs;
      check_bit(got, (k == 3), vertical ? "video_vs pulse" : "video_hs pulse");
    end
    game_hs = 1'b0;
    game_vs = 1'b0;
    repeat (3) @(negedge clk_25_175);
  endtask

  task automatic test_sync_pulses();
    sync_pulse_check(1'b0);
    sync_pulse_check(1'b1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed           = 32'h068a71cb;
    error_count    = 0;
    check_count    = 0;
    cycle_count    = 0;
    clk_25_175     = 1'b0;
    reset          = 1'b1;
    // busy inputs during reset that the reset has to override
    bridge_addr    = ADDR_TEST_MODE;
    bridge_wr      = 1'b1;
    bridge_wr_data = '1;
    cont1_key      = '1;
    cont2_key      = '1;
    game_r         = '1;
    game_g         = '1;
    game_b         = '1;
    game_hs        = 1'b1;
    game_vs        = 1'b1;
    game_hblank    = 1'b0;
    game_vblank    = 1'b0;
    // two reset cycles
    repeat (2) @(negedge clk_25_175);
    reset          = 1'b0;
    bridge_addr    = '0;
    bridge_wr      = 1'b0;
    bridge_wr_data = '0;
    cont1_key      = '0;
    cont2_key      = '0;
    game_r         = '0;
    game_g         = '0;
    game_b         = '0;
    game_hs        = 1'b0;
    game_vs        = 1'b0;

    test_reset_state();
    test_settings();
    test_buttons();
    test_pixels();
    test_sync_pulses();

    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
asteroids_pkg.sv
bridge_if.sv
core_settings_regs.sv
input_sync.sv
arcade_button_map.sv
video_scan_out.sv
asteroids_core_wrap.sv
tb_asteroids_core_wrap.sv
